/* dv/slowControlLoaderTb.sv */
`timescale 1ns/1ns
`default_nettype none

module slowControlLoaderTb;
  import slowControlPkg::*;

  localparam int driveDelay    = 10;     // Input skew after clk rise
  localparam int timeoutCycles = 30000;  // 4 loads of about 4200 clk each, plus margin

  logic     clk;
  logic     slowClock;
  logic     rstN;
  logic     select;
  logic     loadStart;
  scImage_t scImage;
  rsImage_t rsImage;
  wire      loadDone;
  wire      srSelect;
  wire      srRstb;
  wire      srCk;
  wire      srIn;

  logic [15:0] lfsrState;     // Stimulus generator state
  scImage_t    curSc;         // Image handed to the DUT
  rsImage_t    curRs;
  logic        curSel;
  int          curLen;        // Bits expected in the current load
  string       curTest;
  int          bitCount;      // srCk rises this load
  int          rstLowCycles;  // slowClock cycles with srRstb low
  int          firstBitRst;   // rstLowCycles seen at the first srCk rise
  int          doneCount;     // loadDone pulses since reset
  int          doneBitCount;  // bitCount when loadDone was seen
  int          testErrors;
  int          errorCount;
  int          testsRun;
  int          testsFailed;
  int          cycleCount;

  slowControlLoader #(
    .fifoDepthLog2 (6)
  ) u_dut (
    .clk       (clk),
    .slowClock (slowClock),
    .rstN      (rstN),
    .select    (select),
    .loadStart (loadStart),
    .scImage   (scImage),
    .rsImage   (rsImage),
    .loadDone  (loadDone),
    .srSelect  (srSelect),
    .srRstb    (srRstb),
    .srCk      (srCk),
    .srIn      (srIn)
  );

  bind slowControlLoader slowControlLoaderAssert u_protocolChecks (
    .clk       (clk),
    .slowClock (slowClock),
    .rstN      (rstN),
    .srRstb    (srRstb),
    .srCk      (srCk),
    .loadDone  (loadDone),
    .fifoWrEn  (fifoWrEn),
    .fifoFull  (fifoFull)
  );

  ////////////////////////////////////////////////////////////
  // Clocks and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;        // 100 ns
  end

  initial begin
    slowClock = 1'b0;
    forever #175 slowClock = ~slowClock;  // 350 ns
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d clk cycles", timeoutCycles);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////////////////////////

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Chip sees the selected image MSB first
  function automatic logic expectedBit(input logic sel, input scImage_t sc,
                                       input rsImage_t rs, input int idx);
    return sel ? sc[SC_BITS-1-idx] : rs[RS_BITS-1-idx];
  endfunction

  task automatic fillImages();
    for (int i = 0; i < SC_BITS; i++) begin
      lfsrState = lfsrNext(lfsrState);
      curSc[i]  = lfsrState[0];    // One step per bit
    end
    for (int i = 0; i < RS_BITS; i++) begin
      lfsrState = lfsrNext(lfsrState);
      curRs[i]  = lfsrState[0];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Pin capture and on-the-fly compare
  ////////////////////////////////////////////////////////////

  always @(posedge srCk) begin : captureBits
    logic expBit;
    if (rstN) begin
      assert (srRstb === 1'b1) else begin
        $display("srCk rose while srRstb was low in test %s", curTest);
        testErrors++;
      end
      if (bitCount == 0) begin
        firstBitRst = rstLowCycles;  // Reset length before first bit
      end
      if (bitCount < curLen) begin
        expBit = expectedBit(curSel, curSc, curRs, bitCount);
        assert (srIn === expBit) else begin
          $display("ERR %s bit %0d: expected %b, actual %b", curTest, bitCount, expBit, srIn);
          testErrors++;
        end
      end
      assert (srSelect === curSel) else begin
        $display("ERR %s srSelect: expected %b, actual %b", curTest, curSel, srSelect);
        testErrors++;
      end
      bitCount++;
    end
  end

  always @(negedge slowClock) begin
    if (rstN && (srRstb === 1'b0)) begin
      rstLowCycles++;
    end
    if (rstN && (loadDone === 1'b1)) begin
      doneBitCount = bitCount;       // Must already hold every bit
      doneCount++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Check and test helpers
  ////////////////////////////////////////////////////////////

  task automatic checkValue(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("ERR %s %s: expected %0d, actual %0d", curTest, what, expected, actual);
      testErrors++;
    end
  endtask

  task automatic checkLevel(input string what, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("ERR %s %s: expected %b, actual %b", curTest, what, expected, actual);
      testErrors++;
    end
  endtask

  task automatic startTest(input string name);
    curTest    = name;
    testErrors = 0;
  endtask

  task automatic closeTest();
    testsRun++;
    errorCount += testErrors;
    if (testErrors == 0) begin
      $display("Test %s: passed", curTest);
    end else begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", curTest, testErrors);
    end
  endtask

  // One full load; settle leaves time to catch a stray second loadDone
  task automatic runLoad(input logic sel, input bit settle);
    int startDone;
    fillImages();
    @(posedge clk);
    #driveDelay;
    bitCount     = 0;
    rstLowCycles = 0;
    firstBitRst  = -1;
    doneBitCount = -1;
    curSel       = sel;
    curLen       = sel ? SC_BITS : RS_BITS;
    startDone    = doneCount;
    select       = sel;
    scImage      = curSc;
    rsImage      = curRs;
    loadStart    = 1'b1;
    @(posedge clk);
    #driveDelay;
    loadStart = 1'b0;
    wait (doneCount != startDone);   // End of this load
    if (settle) begin
      repeat (20) @(posedge slowClock);
    end
    checkValue("srCk rises", curLen, bitCount);
    checkValue("srRstb low cycles", SR_RESET_CYCLES, rstLowCycles);
    checkValue("srRstb low before first bit", SR_RESET_CYCLES, firstBitRst);
    checkValue("bits before loadDone", curLen, doneBitCount);
    checkValue("loadDone pulses", 1, doneCount - startDone);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : mainSeq
    rstN        = 1'b0;
    select      = 1'b0;
    loadStart   = 1'b0;
    scImage     = '0;
    rsImage     = '0;
    lfsrState   = 16'd61;            // Seed
    curSel      = 1'b0;
    curLen      = 0;
    bitCount    = 0;
    doneCount   = 0;
    errorCount  = 0;
    testsRun    = 0;
    testsFailed = 0;
    startTest("idleAfterReset");
    repeat (16) @(posedge clk);
    #driveDelay rstN = 1'b1;
    repeat (4) @(posedge slowClock);
    @(posedge clk);
    #driveDelay;
    checkLevel("srCk", 1'b0, srCk);
    checkLevel("srIn", 1'b0, srIn);
    checkLevel("srRstb", 1'b1, srRstb);
    checkLevel("loadDone", 1'b0, loadDone);
    closeTest();

    startTest("slowControlLoad");
    runLoad(1'b1, 1'b1);
    closeTest();

    startTest("readScopeLoad");
    runLoad(1'b0, 1'b1);
    closeTest();

    startTest("backToBackSlowControl");
    runLoad(1'b1, 1'b0);             // Next load starts right after loadDone
    closeTest();

    startTest("backToBackReadScope");
    runLoad(1'b0, 1'b1);
    checkValue("total loadDone pulses", 4, doneCount);
    closeTest();

    errorCount += u_dut.u_protocolChecks.failCount;  // Bound assertion failures
    $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/slowControlLoader_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module slowControlLoaderAssert (
  input wire clk,
  input wire slowClock,
  input wire rstN,
  input wire srRstb,
  input wire srCk,
  input wire loadDone,
  input wire fifoWrEn,    // Generator write strobe
  input wire fifoFull     // FIFO back-pressure
);

  int failCount = 0;      // Protocol violations so far

  ////////////////////////////////////////////////////////////
  // Chip pin protocol
  ////////////////////////////////////////////////////////////

  // Chip register must be out of reset on every sampling edge
  srCkOutOfReset: assert property (@(posedge slowClock) disable iff (!rstN)
    $rose(srCk) |-> srRstb)
    else begin
      $error("srCk rose while srRstb was low");
      failCount++;
    end

  loadDoneSingle: assert property (@(posedge slowClock) disable iff (!rstN)
    loadDone |=> !loadDone)
    else begin
      $error("loadDone stayed high for more than one slowClock cycle");
      failCount++;
    end

  ////////////////////////////////////////////////////////////
  // FIFO write side
  ////////////////////////////////////////////////////////////

  noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN)
    !(fifoWrEn && fifoFull))
    else begin
      $error("fifoWrEn high while fifoFull was high");
      failCount++;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/slowControlPkg.sv
hw/parameterGenerator.sv
hw/configFifo.sv
hw/pulseSync.sv
hw/bitShiftOut.sv
hw/slowControlLoader.sv
dv/slowControlLoader_assert.sv
dv/slowControlLoaderTb.sv

/* hw/bitShiftOut.sv */
`timescale 1ns/1ns
`default_nettype none

module bitShiftOut (
  input  wire                           slowClock,   // Chip serial clock domain
  input  wire                           rstN,
  input  wire                           shiftStart,  // Whole image is in the FIFO
  input  wire                           fifoEmpty,
  input  wire slowControlPkg::cfgWord_t fifoRdData,
  output logic                          fifoRdEn,
  output logic                          srRstb,      // Chip register reset, active low
  output logic                          srCk,
  output logic                          srIn,
  output logic                          loadDone
);
  import slowControlPkg::*;

  localparam int rstCntBits = (SR_RESET_CYCLES > 1) ? $clog2(SR_RESET_CYCLES) : 1;
  localparam int bitCntBits = $clog2(WORD_BITS);

  shiftState_t           state;
  logic [rstCntBits-1:0] rstCnt;   // Cycles spent in reset
  logic [bitCntBits-1:0] bitCnt;   // Bit within current word
  cfgWord_t              wordReg;  // Word being shifted

  // Pop on the edge that leaves ssPop
  assign fifoRdEn = (state == ssPop) && !fifoEmpty;

  ////////////////////////////////////////////////////////////
  // Control FSM and pin registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge slowClock or negedge rstN) begin
    if (!rstN) begin
      state    <= ssIdle;
      rstCnt   <= '0;
      bitCnt   <= '0;
      srRstb   <= 1'b1;
      srCk     <= 1'b0;
      srIn     <= 1'b0;
      loadDone <= 1'b0;
    end else begin
      loadDone <= 1'b0;                            // Pulse by default low
      case (state)
        ssIdle: begin
          if (shiftStart) begin
            state  <= ssReset;
            rstCnt <= '0;
            srRstb <= 1'b0;                        // Clear the chip register
          end
        end
        ssReset: begin
          if (rstCnt == rstCntBits'(SR_RESET_CYCLES - 1)) begin
            srRstb <= 1'b1;
            state  <= ssPop;
          end else begin
            rstCnt <= rstCnt + 1'b1;
          end
        end
        ssPop: begin
          if (!fifoEmpty) begin
            bitCnt <= '0;
            srIn   <= fifoRdData[WORD_BITS-1];     // MSB first
            state  <= ssClockLow;
          end
        end
        ssClockLow: begin
          srCk  <= 1'b1;                           // Chip samples on this rise
          state <= ssClockHigh;
        end
        ssClockHigh: begin
          srCk <= 1'b0;
          if (bitCnt == bitCntBits'(WORD_BITS - 1)) begin
            if (fifoEmpty) begin                   // Image fully sent
              srIn     <= 1'b0;
              loadDone <= 1'b1;
              state    <= ssDone;
            end else begin
              state <= ssPop;
            end
          end else begin
            bitCnt <= bitCnt + 1'b1;
            srIn   <= wordReg[WORD_BITS-2];        // Next bit down
            state  <= ssClockLow;
          end
        end
        ssDone: begin
          state <= ssIdle;
        end
        default: begin
          state <= ssIdle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Word shift register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge slowClock) begin
    if (fifoRdEn) begin
      wordReg <= fifoRdData;
    end else if (state == ssClockHigh) begin
      wordReg <= wordReg << 1;                     // Keep next bit at WORD_BITS-2
    end
  end

endmodule

`default_nettype wire

/* hw/configFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module configFifo #(
  parameter int fifoDepthLog2 = 6               // 64 words
) (
  input  wire                           wrClk,
  input  wire                           rdClk,
  input  wire                           rstN,
  input  wire                           wrEn,
  input  wire slowControlPkg::cfgWord_t wrData,
  output logic                          full,
  input  wire                           rdEn,
  output slowControlPkg::cfgWord_t      rdData,  // Valid while not empty
  output logic                          empty
);
  import slowControlPkg::*;

  localparam int depth   = 2 ** fifoDepthLog2;
  localparam int ptrBits = fifoDepthLog2 + 1;   // Extra wrap bit

  cfgWord_t mem [depth];

  logic [ptrBits-1:0] wrBin;
  logic [ptrBits-1:0] wrBinNext;
  logic [ptrBits-1:0] wrGray;
  logic [ptrBits-1:0] rdBin;
  logic [ptrBits-1:0] rdBinNext;
  logic [ptrBits-1:0] rdGray;
  logic [ptrBits-1:0] rdGraySync1;  // rdGray in wrClk domain
  logic [ptrBits-1:0] rdGraySync2;
  logic [ptrBits-1:0] wrGraySync1;  // wrGray in rdClk domain
  logic [ptrBits-1:0] wrGraySync2;
  logic               wrAccept;
  logic               rdAccept;

  function automatic logic [ptrBits-1:0] toGray(input logic [ptrBits-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  ////////////////////////////////////////////////////////////
  // Write domain
  ////////////////////////////////////////////////////////////

  assign wrAccept  = wrEn && !full;
  assign wrBinNext = wrBin + ptrBits'(wrAccept);

  always_ff @(posedge wrClk or negedge rstN) begin
    if (!rstN) begin
      wrBin  <= '0;
      wrGray <= '0;
    end else begin
      wrBin  <= wrBinNext;
      wrGray <= toGray(wrBinNext);                // Registered, glitch free crossing
    end
  end

  always_ff @(posedge wrClk) begin
    if (wrAccept) begin
      mem[wrBin[fifoDepthLog2-1:0]] <= wrData;
    end
  end

  always_ff @(posedge wrClk or negedge rstN) begin
    if (!rstN) begin
      rdGraySync1 <= '0;
      rdGraySync2 <= '0;
    end else begin
      rdGraySync1 <= rdGray;
      rdGraySync2 <= rdGraySync1;
    end
  end

  // Full when the top two Gray bits differ and the rest match
  assign full = (wrGray == {~rdGraySync2[ptrBits-1 -: 2], rdGraySync2[ptrBits-3:0]});

  ////////////////////////////////////////////////////////////
  // Read domain
  ////////////////////////////////////////////////////////////

  assign rdAccept  = rdEn && !empty;
  assign rdBinNext = rdBin + ptrBits'(rdAccept);

  always_ff @(posedge rdClk or negedge rstN) begin
    if (!rstN) begin
      rdBin  <= '0;
      rdGray <= '0;
    end else begin
      rdBin  <= rdBinNext;
      rdGray <= toGray(rdBinNext);
    end
  end

  always_ff @(posedge rdClk or negedge rstN) begin
    if (!rstN) begin
      wrGraySync1 <= '0;
      wrGraySync2 <= '0;
    end else begin
      wrGraySync1 <= wrGray;
      wrGraySync2 <= wrGraySync1;
    end
  end

  assign empty  = (rdGray == wrGraySync2);        // Pointers equal
  assign rdData = mem[rdBin[fifoDepthLog2-1:0]];  // First word falls through

endmodule

`default_nettype wire

/* hw/parameterGenerator.sv */
`timescale 1ns/1ns
`default_nettype none

module parameterGenerator (
  input  wire                           clk,         // Fast system clock
  input  wire                           rstN,
  input  wire                           select,      // 1 slow control, 0 read scope
  input  wire                           loadStart,   // One clk-cycle request
  input  wire slowControlPkg::scImage_t scImage,
  input  wire slowControlPkg::rsImage_t rsImage,
  input  wire                           fifoFull,    // Stalls the writes
  output logic                          fifoWrEn,
  output slowControlPkg::cfgWord_t      fifoWrData,
  output logic                          genDone      // Pulse after the last write
);
  import slowControlPkg::*;

  localparam int scWords = SC_BITS / WORD_BITS;  // 37 words
  localparam int rsWords = RS_BITS / WORD_BITS;  // 4 words
  localparam int cntBits = $clog2(scWords + 1);

  genState_t          state;
  logic [cntBits-1:0] wordCnt;   // Words still to write
  scImage_t           imageReg;  // Latched image, left aligned

  ////////////////////////////////////////////////////////////
  // FIFO write side
  ////////////////////////////////////////////////////////////

  assign fifoWrEn   = (state == gsWrite) && !fifoFull;  // Never while full
  assign fifoWrData = imageReg[SC_BITS-1 -: WORD_BITS];  // Top word goes first
  assign genDone    = (state == gsDone);

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= gsIdle;
      wordCnt <= '0;
    end else begin
      case (state)
        gsIdle: begin
          if (loadStart) begin                     // Requests while busy are dropped
            state   <= gsWrite;
            wordCnt <= select ? cntBits'(scWords)
                              : cntBits'(rsWords);
          end
        end
        gsWrite: begin
          if (fifoWrEn) begin
            wordCnt <= wordCnt - 1'b1;
            if (wordCnt == cntBits'(1)) begin    // Last word on this edge
              state <= gsDone;
            end
          end
        end
        gsDone: begin
          state <= gsIdle;                         // genDone lasts one cycle
        end
        default: begin
          state <= gsIdle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Image shift register
  ////////////////////////////////////////////////////////////

  // Read scope sits in the top RS_BITS, the tail is never sent
  always_ff @(posedge clk) begin
    if ((state == gsIdle) && loadStart) begin
      if (select) begin
        imageReg <= scImage;
      end else begin
        imageReg <= {rsImage, {(SC_BITS - RS_BITS){1'b0}}};
      end
    end else if (fifoWrEn) begin
      imageReg <= imageReg << WORD_BITS;           // Next word to the top
    end
  end

endmodule

`default_nettype wire

/* hw/pulseSync.sv */
`timescale 1ns/1ns
`default_nettype none

module pulseSync (
  input  wire  srcClk,
  input  wire  dstClk,
  input  wire  rstN,
  input  wire  srcPulse,   // One srcClk cycle
  output logic dstPulse    // One dstClk cycle
);

  logic       srcToggle;   // Flips once per source pulse
  logic [2:0] dstSync;     // Two sync stages plus edge history

  ////////////////////////////////////////////////////////////
  // Source side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge srcClk or negedge rstN) begin
    if (!rstN) begin
      srcToggle <= 1'b0;
    end else if (srcPulse) begin
      srcToggle <= ~srcToggle;
    end
  end

  ////////////////////////////////////////////////////////////
  // Destination side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge dstClk or negedge rstN) begin
    if (!rstN) begin
      dstSync <= '0;
    end else begin
      dstSync <= {dstSync[1:0], srcToggle};
    end
  end

  assign dstPulse = dstSync[2] ^ dstSync[1];  // Any level change is one pulse

endmodule

`default_nettype wire

/* hw/slowControlLoader.sv */
`timescale 1ns/1ns
`default_nettype none

module slowControlLoader #(
  parameter int fifoDepthLog2 = 6                  // Must hold a full slow-control image
) (
  input  wire                           clk,
  input  wire                           slowClock,
  input  wire                           rstN,
  input  wire                           select,     // 1 slow control, 0 read scope
  input  wire                           loadStart,
  input  wire slowControlPkg::scImage_t scImage,
  input  wire slowControlPkg::rsImage_t rsImage,
  output wire                           loadDone,
  output wire                           srSelect,   // Register choice on the chip
  output wire                           srRstb,
  output wire                           srCk,
  output wire                           srIn
);
  import slowControlPkg::*;

  // The shifter starts only once every word is stored
  if ((2 ** fifoDepthLog2) < (SC_BITS / WORD_BITS)) begin : gDepthCheck
    $error("configFifo too shallow for one slow-control image");
  end
  if (((SC_BITS % WORD_BITS) != 0) || ((RS_BITS % WORD_BITS) != 0)) begin : gWidthCheck
    $error("Image widths must be whole FIFO words");
  end

  cfgWord_t fifoWrData;
  cfgWord_t fifoRdData;
  logic     fifoWrEn;
  logic     fifoFull;
  logic     fifoRdEn;
  logic     fifoEmpty;
  logic     genDone;     // clk domain
  logic     shiftStart;  // slowClock domain

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  parameterGenerator u_gen (
    .clk        (clk),
    .rstN       (rstN),
    .select     (select),
    .loadStart  (loadStart),
    .scImage    (scImage),
    .rsImage    (rsImage),
    .fifoFull   (fifoFull),
    .fifoWrEn   (fifoWrEn),
    .fifoWrData (fifoWrData),
    .genDone    (genDone)
  );

  configFifo #(
    .fifoDepthLog2 (fifoDepthLog2)
  ) u_fifo (
    .wrClk  (clk),
    .rdClk  (slowClock),
    .rstN   (rstN),
    .wrEn   (fifoWrEn),
    .wrData (fifoWrData),
    .full   (fifoFull),
    .rdEn   (fifoRdEn),
    .rdData (fifoRdData),
    .empty  (fifoEmpty)
  );

  pulseSync u_sync (
    .srcClk   (clk),
    .dstClk   (slowClock),
    .rstN     (rstN),
    .srcPulse (genDone),
    .dstPulse (shiftStart)
  );

  bitShiftOut u_shift (
    .slowClock  (slowClock),
    .rstN       (rstN),
    .shiftStart (shiftStart),
    .fifoEmpty  (fifoEmpty),
    .fifoRdData (fifoRdData),
    .fifoRdEn   (fifoRdEn),
    .srRstb     (srRstb),
    .srCk       (srCk),
    .srIn       (srIn),
    .loadDone   (loadDone)
  );

  assign srSelect = select;  // Straight to the chip pin

endmodule

`default_nettype wire

/* hw/slowControlPkg.sv */
`default_nettype none

package slowControlPkg;

  ////////////////////////////////////////////////////////////
  // Register geometry
  ////////////////////////////////////////////////////////////

  localparam int WORD_BITS       = 16;   // One FIFO word
  localparam int SC_BITS         = 592;  // Slow-control chain length
  localparam int RS_BITS         = 64;   // Read-scope chain length
  localparam int SR_RESET_CYCLES = 4;    // srRstb low time in slowClock cycles

  typedef logic [WORD_BITS-1:0] cfgWord_t;  // FIFO payload
  typedef logic [SC_BITS-1:0]   scImage_t;  // Full slow-control image, MSB shifted first
  typedef logic [RS_BITS-1:0]   rsImage_t;  // Read-scope image, MSB shifted first

  ////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////

  // Generator in the clk domain
  typedef enum logic [1:0] {
    gsIdle,   // Waiting for loadStart
    gsWrite,  // Pushing words into the FIFO
    gsDone    // One cycle of genDone
  } genState_t;

  // Shifter in the slowClock domain
  typedef enum logic [2:0] {
    ssIdle,       // Waiting for shiftStart
    ssReset,      // Chip register held in reset
    ssPop,        // Fetch next word
    ssClockLow,   // srIn set up, srCk low
    ssClockHigh,  // srCk high, chip samples
    ssDone        // loadDone pulse
  } shiftState_t;

endpackage

`default_nettype wire
